// ==== hw/bp_config.svh ====
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// Predictor geometry
////////////////////////////////////////////////////////////////////////

// Fetch slots per request, one lane each
`define BP_LANES 2

// History table index, taken from pc bits above the word offset
`define BP_INDEX_BITS 8

// Outcome history per entry
// Must equal BP_INDEX_BITS for the xor hash into the pattern table
`define BP_HIST_BITS 8

// Instruction address width
`define BP_ADDR_BITS 32

`endif

// ==== hw/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    ////////////////////////////////////////////////////////////////////
    // Two-bit saturating counter
    ////////////////////////////////////////////////////////////////////

    // Rising order, msb set means predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_e;

    // Step towards the resolved outcome, saturating at both ends
    function automatic ctr_e ctr_next(input ctr_e cur, input logic taken);
        ctr_e nxt;
        nxt = cur;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = STRONG_NT;
        endcase
        return nxt;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Lane result
    ////////////////////////////////////////////////////////////////////

    // One slot's registered prediction
    typedef struct packed {
        logic valid;
        logic taken;
    } lane_res_t;

endpackage

`default_nettype wire

// ==== hw/bp_lane_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_config.svh"

interface bp_lane_if;

    import bp_pkg::*;

    // Lookup for this slot
    logic                     look_valid;
    logic [`BP_ADDR_BITS-1:0] look_pc;

    // Resolved branch, same on every lane
    logic                     upd_valid;
    logic [`BP_ADDR_BITS-1:0] upd_pc;
    logic                     upd_taken;

    // Pipeline step from the collector
    logic                     advance;

    // Registered prediction of this slot
    lane_res_t                res;

    modport src (
        output look_valid,
        output look_pc,
        output upd_valid,
        output upd_pc,
        output upd_taken
    );

    modport lane (
        input  look_valid,
        input  look_pc,
        input  upd_valid,
        input  upd_pc,
        input  upd_taken,
        input  advance,
        output res
    );

    modport sink (
        output advance,
        input  res
    );

endinterface

`default_nettype wire

// ==== hw/bp_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_config.svh"

module bp_dispatch (
    input  wire logic                                    clk,
    input  wire logic                                    rst,

    // Fetch request
    input  wire logic                                    req_valid,
    input  wire logic [`BP_LANES-1:0][`BP_ADDR_BITS-1:0] req_pc,
    input  wire logic [`BP_LANES-1:0]                    req_mask,
    input  wire logic                                    req_ready,

    // Resolved branch
    input  wire logic                                    upd_valid,
    input  wire logic [`BP_ADDR_BITS-1:0]                upd_pc,
    input  wire logic                                    upd_taken,

    bp_lane_if.src                                       lanes [`BP_LANES]
);

    logic                     req_fire;

    logic                     upd_valid_q;
    logic [`BP_ADDR_BITS-1:0] upd_pc_q;
    logic                     upd_taken_q;

    assign req_fire = req_valid && req_ready;

    ////////////////////////////////////////////////////////////////////
    // Update stage
    ////////////////////////////////////////////////////////////////////

    // One register feeds every table copy, so all lanes see
    // the same update in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= upd_valid;
        end
    end

    always_ff @(posedge clk) begin
        upd_pc_q    <= upd_pc;
        upd_taken_q <= upd_taken;
    end

    ////////////////////////////////////////////////////////////////////
    // Fan-out
    ////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `BP_LANES; g++) begin : g_fanout
        // Masked slots still step the lane, but with an empty result
        assign lanes[g].look_valid = req_fire && req_mask[g];
        assign lanes[g].look_pc    = req_pc[g];

        assign lanes[g].upd_valid  = upd_valid_q;
        assign lanes[g].upd_pc     = upd_pc_q;
        assign lanes[g].upd_taken  = upd_taken_q;
    end

endmodule

`default_nettype wire

// ==== hw/bp_local_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_config.svh"

module bp_local_lane (
    input  wire logic clk,
    input  wire logic rst,
    bp_lane_if.lane   port
);

    import bp_pkg::*;

    localparam int IDX_W    = `BP_INDEX_BITS;
    localparam int HIST_W   = `BP_HIST_BITS;
    localparam int ENTRIES  = 1 << IDX_W;
    localparam int PATTERNS = 1 << HIST_W;

    ////////////////////////////////////////////////////////////////////
    // Tables
    ////////////////////////////////////////////////////////////////////

    // Local outcome history per branch, newest outcome in bit 0
    logic [HIST_W-1:0] bht [ENTRIES];

    // Counters, row from history xor pc, column from history
    ctr_e              pht [ENTRIES][PATTERNS];

    // Lookup side
    logic [IDX_W-1:0]  look_idx;
    logic [HIST_W-1:0] look_hist;
    logic [IDX_W-1:0]  look_row;
    ctr_e              look_ctr;

    // Update side
    logic [IDX_W-1:0]  upd_idx;
    logic [HIST_W-1:0] upd_hist;
    logic [IDX_W-1:0]  upd_row;
    ctr_e              upd_ctr;

    // Result register
    logic              res_valid_q;
    logic              res_taken_q;

    ////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////

    // Reads the tables before any update on the same edge
    assign look_idx  = port.look_pc[IDX_W+1:2];
    assign look_hist = bht[look_idx];
    assign look_row  = look_hist ^ look_idx;
    assign look_ctr  = pht[look_row][look_hist];

    ////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////

    assign upd_idx  = port.upd_pc[IDX_W+1:2];
    assign upd_hist = bht[upd_idx];
    assign upd_row  = upd_hist ^ upd_idx;
    assign upd_ctr  = pht[upd_row][upd_hist];

    // Counter is stepped under the old history, then the outcome
    // is shifted in
    always_ff @(posedge clk) begin
        if (rst) begin
            bht <= '{default: '0};
            pht <= '{default: STRONG_NT};
        end else if (port.upd_valid) begin
            bht[upd_idx]          <= {upd_hist[HIST_W-2:0], port.upd_taken};
            pht[upd_row][upd_hist] <= ctr_next(upd_ctr, port.upd_taken);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Result stage
    ////////////////////////////////////////////////////////////////////

    // Held while the collector is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_q <= 1'b0;
        end else if (port.advance) begin
            res_valid_q <= port.look_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (port.advance) begin
            res_taken_q <= look_ctr[1];
        end
    end

    assign port.res = '{valid: res_valid_q, taken: res_taken_q};

endmodule

`default_nettype wire

// ==== hw/bp_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_config.svh"

module bp_collect (
    input  wire logic                         clk,
    input  wire logic                         rst,

    bp_lane_if.sink                           lanes [`BP_LANES],

    // Pipeline step, also the request ready
    output logic                              advance_out,

    // Response
    output logic                              resp_valid,
    input  wire logic                         resp_ready,
    output logic [`BP_LANES-1:0]              resp_taken,
    output logic [$clog2(`BP_LANES)-1:0]      resp_first,
    output logic                              resp_redirect
);

    import bp_pkg::*;

    localparam int FIRST_W = $clog2(`BP_LANES);

    lane_res_t                res [`BP_LANES];
    logic                     advance;

    logic                     any_valid;
    logic [`BP_LANES-1:0]     taken_d;
    logic [FIRST_W-1:0]       first_d;
    logic                     redirect_d;

    logic                     resp_valid_q;
    logic [`BP_LANES-1:0]     resp_taken_q;
    logic [FIRST_W-1:0]       resp_first_q;
    logic                     resp_redirect_q;

    // Move when the output is free or leaving this cycle
    assign advance     = !resp_valid_q || resp_ready;
    assign advance_out = advance;

    for (genvar g = 0; g < `BP_LANES; g++) begin : g_gather
        assign lanes[g].advance = advance;
        assign res[g]           = lanes[g].res;
        assign taken_d[g]       = res[g].valid && res[g].taken;
    end

    ////////////////////////////////////////////////////////////////////
    // Response forming
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        any_valid = 1'b0;
        first_d   = '0;
        for (int i = 0; i < `BP_LANES; i++) begin
            any_valid = any_valid || res[i].valid;
        end
        // Scan downwards so the lowest taken slot wins
        for (int i = `BP_LANES - 1; i >= 0; i--) begin
            if (taken_d[i]) begin
                first_d = FIRST_W'(i);
            end
        end
    end

    assign redirect_d = |taken_d;

    ////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid_q <= 1'b0;
        end else if (advance) begin
            resp_valid_q <= any_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            resp_taken_q    <= taken_d;
            resp_first_q    <= first_d;
            resp_redirect_q <= redirect_d;
        end
    end

    assign resp_valid    = resp_valid_q;
    assign resp_taken    = resp_taken_q;
    assign resp_first    = resp_first_q;
    assign resp_redirect = resp_redirect_q;

endmodule

`default_nettype wire

// ==== hw/bp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_config.svh"

module bp_top (
    input  wire logic                                    clk,
    input  wire logic                                    rst,

    // Fetch request, one address per slot
    input  wire logic                                    req_valid,
    output logic                                         req_ready,
    input  wire logic [`BP_LANES-1:0][`BP_ADDR_BITS-1:0] req_pc,
    input  wire logic [`BP_LANES-1:0]                    req_mask,

    // Prediction response
    output logic                                         resp_valid,
    input  wire logic                                    resp_ready,
    output logic [`BP_LANES-1:0]                         resp_taken,
    output logic [$clog2(`BP_LANES)-1:0]                 resp_first,
    output logic                                         resp_redirect,

    // Resolved branch, always accepted
    input  wire logic                                    upd_valid,
    input  wire logic [`BP_ADDR_BITS-1:0]                upd_pc,
    input  wire logic                                    upd_taken
);

    ////////////////////////////////////////////////////////////////////
    // Lane buses
    ////////////////////////////////////////////////////////////////////

    bp_lane_if lane_bus [`BP_LANES] ();

    // Requests and updates in
    bp_dispatch i_dispatch (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_pc    (req_pc),
        .req_mask  (req_mask),
        .req_ready (req_ready),
        .upd_valid (upd_valid),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken),
        .lanes     (lane_bus)
    );

    // One full table copy per slot
    for (genvar g = 0; g < `BP_LANES; g++) begin : g_lane
        bp_local_lane i_lane (
            .clk  (clk),
            .rst  (rst),
            .port (lane_bus[g])
        );
    end

    // Response out, ready loops back to the dispatcher
    bp_collect i_collect (
        .clk           (clk),
        .rst           (rst),
        .lanes         (lane_bus),
        .advance_out   (req_ready),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_taken    (resp_taken),
        .resp_first    (resp_first),
        .resp_redirect (resp_redirect)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/tb_bp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_config.svh"

module tb_bp_top;

    localparam int TIMEOUT  = 200;
    localparam int SEED     = 56;
    // Lane stage, then the output register
    localparam int RESP_LAT = 2;

    localparam logic [31:0] PC_A = 32'h0000_0040;
    localparam logic [31:0] PC_B = 32'h0000_0100;
    localparam logic [31:0] PC_C = 32'h0000_0208;

    // One table row for training or for a two-slot prediction
    typedef struct packed {
        logic        train;
        logic [31:0] pc0;
        logic [31:0] pc1;
        logic [1:0]  mask;
        logic        outcome;
        logic [7:0]  count;
        logic [1:0]  exp_taken;
        logic        exp_first;
        logic        exp_redirect;
    } row_t;

    logic                                    clk;
    logic                                    rst;
    logic                                    req_valid;
    logic                                    req_ready;
    logic [`BP_LANES-1:0][`BP_ADDR_BITS-1:0] req_pc;
    logic [`BP_LANES-1:0]                    req_mask;
    logic                                    resp_valid;
    logic                                    resp_ready;
    logic [`BP_LANES-1:0]                    resp_taken;
    logic [$clog2(`BP_LANES)-1:0]            resp_first;
    logic                                    resp_redirect;
    logic                                    upd_valid;
    logic [`BP_ADDR_BITS-1:0]                upd_pc;
    logic                                    upd_taken;

    row_t rows [$];
    row_t exp_q [$];
    int   acc_q [$];
    bit   lat_q [$];
    int   cycle = 0;
    int   stall_from;
    bit   stall_en = 1'b0;

    // Reference copy of the history and counter tables
    logic [7:0] m_bht [256];
    logic [1:0] m_pht [256][256];

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    bp_top i_bp_top (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_pc        (req_pc),
        .req_mask      (req_mask),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_taken    (resp_taken),
        .resp_first    (resp_first),
        .resp_redirect (resp_redirect),
        .upd_valid     (upd_valid),
        .upd_pc        (upd_pc),
        .upd_taken     (upd_taken)
    );

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////

    // Two-bit saturating step towards the outcome
    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic t);
        if (t) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic void model_update(input logic [31:0] pc, input logic t);
        logic [7:0] idx;
        logic [7:0] h;
        idx = pc[9:2];
        h   = m_bht[idx];
        m_pht[h ^ idx][h] = sat_step(m_pht[h ^ idx][h], t);
        m_bht[idx] = {h[6:0], t};
    endfunction

    function automatic logic model_taken(input logic [31:0] pc);
        logic [7:0] idx;
        logic [7:0] h;
        idx = pc[9:2];
        h   = m_bht[idx];
        return m_pht[h ^ idx][h][1];
    endfunction

    function automatic void fill_expected();
        row_t r;
        logic t0;
        logic t1;
        for (int i = 0; i < 256; i++) begin
            m_bht[i] = '0;
            for (int j = 0; j < 256; j++) begin
                m_pht[i][j] = 2'd0;
            end
        end
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.train) begin
                for (int k = 0; k < r.count; k++) begin
                    model_update(r.pc0, r.outcome);
                end
            end else begin
                t0 = r.mask[0] && model_taken(r.pc0);
                t1 = r.mask[1] && model_taken(r.pc1);
                r.exp_taken    = {t1, t0};
                r.exp_first    = !t0 && t1;
                r.exp_redirect = t0 || t1;
                rows[i] = r;
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////

    function automatic void add_train(input logic [31:0] pc, input logic t, input int n);
        row_t r;
        r = '0;
        r.train   = 1'b1;
        r.pc0     = pc;
        r.outcome = t;
        r.count   = 8'(n);
        rows.push_back(r);
    endfunction

    function automatic void add_predict(input logic [31:0] pc0, input logic [31:0] pc1,
                                        input logic [1:0] mask);
        row_t r;
        r = '0;
        r.pc0  = pc0;
        r.pc1  = pc1;
        r.mask = mask;
        rows.push_back(r);
    endfunction

    function automatic void build_rows();
        // Fresh tables
        add_predict(PC_A, PC_B, 2'b11);
        add_predict(PC_C, PC_A, 2'b11);
        // Taken through a full history sweep, then reversed
        add_train(PC_A, 1'b1, 12);
        add_predict(PC_A, PC_B, 2'b11);
        add_predict(PC_B, PC_A, 2'b11);
        add_train(PC_A, 1'b0, 12);
        add_predict(PC_A, PC_B, 2'b11);
        // Opposite training on two branches
        add_train(PC_B, 1'b1, 12);
        add_train(PC_C, 1'b0, 6);
        add_predict(PC_A, PC_B, 2'b11);
        add_predict(PC_C, PC_B, 2'b11);
        add_train(PC_A, 1'b1, 12);
        add_predict(PC_A, PC_B, 2'b11);
        add_predict(PC_A, PC_B, 2'b10);
        add_predict(PC_A, PC_B, 2'b01);
        // Back-pressure section
        stall_from = rows.size();
        for (int k = 0; k < 10; k++) begin
            if (k == 5) begin
                add_train(PC_C, 1'b1, 12);
            end
            add_predict(k[0] ? PC_A : PC_C, k[1] ? PC_B : PC_C, 2'((k % 3) + 1));
        end
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check(input string name, input logic [31:0] want, input logic [31:0] got);
        if (want !== got) begin
            fail_now($sformatf("error at %0t: %s expected %0h, got %0h",
                               $time, name, want, got));
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Random stalls only once the table reaches its back-pressure rows
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            if (stall_en) begin
                resp_ready <= ($urandom % 3) != 0;
            end else begin
                resp_ready <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin : monitor
        row_t want;
        int   acc;
        bit   lat;
        if (!rst && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                fail_now("a response arrived with no request outstanding");
            end else begin
                want = exp_q.pop_front();
                acc  = acc_q.pop_front();
                lat  = lat_q.pop_front();
                check("resp_taken", want.exp_taken, resp_taken);
                check("resp_first", want.exp_first, resp_first);
                check("resp_redirect", want.exp_redirect, resp_redirect);
                if (lat) begin
                    check("response latency", RESP_LAT, cycle - acc);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////////////

    task automatic wait_reset();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) fail_now("reset was never released");
        end while (rst);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) fail_now("timed out waiting for outstanding responses");
        end
    endtask

    task automatic apply_predict(input row_t r);
        int n;
        n = 0;
        req_valid <= 1'b1;
        req_pc    <= {r.pc1, r.pc0};
        req_mask  <= r.mask;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) fail_now("timed out waiting for req_ready");
        end while (!req_ready);
        exp_q.push_back(r);
        acc_q.push_back(cycle);
        lat_q.push_back(!stall_en);
    endtask

    task automatic apply_train(input row_t r);
        req_valid <= 1'b0;
        for (int k = 0; k < r.count; k++) begin
            upd_valid <= 1'b1;
            upd_pc    <= r.pc0;
            upd_taken <= r.outcome;
            @(posedge clk);
        end
        upd_valid <= 1'b0;
        // Update register, then the table write
        repeat (2) @(posedge clk);
    endtask

    initial begin
        req_valid  = 1'b0;
        req_pc     = '0;
        req_mask   = '0;
        resp_ready = 1'b1;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        build_rows();
        fill_expected();
        wait_reset();
        for (int i = 0; i < rows.size(); i++) begin
            if (i == stall_from) begin
                req_valid <= 1'b0;
                drain();
                stall_en <= 1'b1;
            end
            if (rows[i].train) begin
                apply_train(rows[i]);
            end else begin
                apply_predict(rows[i]);
            end
        end
        req_valid <= 1'b0;
        drain();
        // Catch any late duplicate
        repeat (10) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/bp_pkg.sv
hw/bp_lane_if.sv
hw/bp_dispatch.sv
hw/bp_local_lane.sv
hw/bp_collect.sv
hw/bp_top.sv
test/tb_clock_gen.sv
test/tb_bp_top.sv

// ==== Bender.yml ====
package:
  name: bp_local

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bp_pkg.sv
      - hw/bp_lane_if.sv
      - hw/bp_dispatch.sv
      - hw/bp_local_lane.sv
      - hw/bp_collect.sv
      - hw/bp_top.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - test/tb_clock_gen.sv
      - test/tb_bp_top.sv
